/* common/ir_keys_pkg.sv */
package ir_keys_pkg;

    // Remote key codes
    localparam logic [7:0] KEY_CAM      = 8'h0f;
    localparam logic [7:0] KEY_IR       = 8'h13;
    localparam logic [7:0] KEY_IDLE     = 8'h10;
    localparam logic [7:0] KEY_STOP     = 8'h0c;
    localparam logic [7:0] KEY_LEFT     = 8'h07;
    localparam logic [7:0] KEY_RIGHT    = 8'h09;
    localparam logic [7:0] KEY_FAST     = 8'h02;
    localparam logic [7:0] KEY_MEDIUM   = 8'h05;
    localparam logic [7:0] KEY_SLOW     = 8'h08;
    localparam logic [7:0] KEY_REVERSE  = 8'h00;
    localparam logic [7:0] KEY_LREVERSE = 8'h11;
    localparam logic [7:0] KEY_RREVERSE = 8'h17;

    localparam logic [7:0] KEY_NONE     = 8'hff;   // Nothing held

    // Cruise speed selector
    typedef enum logic [1:0] {
        spd_slow   = 2'b00,
        spd_medium = 2'b01,
        spd_fast   = 2'b10,
        spd_halt   = 2'b11
    } speed_t;

endpackage

/* common/robot_pkg.sv */
package robot_pkg;

    // Operating mode of the car
    typedef enum logic [1:0] {
        mode_idle = 2'b00,
        mode_cam  = 2'b01,
        mode_ir   = 2'b10
    } mode_t;

    // Sub-state while following the camera
    typedef enum logic [1:0] {
        cam_search = 2'b00,
        cam_follow = 2'b01,
        cam_pause  = 2'b11              // Not in camera mode
    } cam_state_t;

    typedef enum logic [3:0] {
        cmd_stop     = 4'd0,
        cmd_left     = 4'd1,
        cmd_right    = 4'd2,
        cmd_slow     = 4'd3,
        cmd_medium   = 4'd4,
        cmd_fast     = 4'd5,
        cmd_reverse  = 4'd6,
        cmd_lreverse = 4'd7,
        cmd_rreverse = 4'd8,
        cmd_hard_l   = 4'd9,
        cmd_hard_r   = 4'd10
    } drive_cmd_t;

    typedef enum logic {
        dir_fwd = 1'b0,
        dir_bwd = 1'b1
    } motor_dir_t;

    // Target direction reported by the camera tracker
    typedef enum logic [2:0] {
        cdir_none   = 3'd0,
        cdir_left   = 3'd1,
        cdir_right  = 3'd2,
        cdir_center = 3'd3
    } cam_dir_t;

endpackage

/* files.f */
common/robot_pkg.sv
common/ir_keys_pkg.sv
hdl/ir_key_hold.sv
mode_fsm/mode_fsm.sv
hdl/motor_pwm.sv
hdl/seg_display.sv
hdl/robot_top.sv
tb/robot_tb.sv

/* hdl/ir_key_hold.sv */
`timescale 1ns/100ps

module ir_key_hold
    import ir_keys_pkg::*;
#(
    parameter int HOLD_CYCLES = 5_000_000
) (
    input  logic       clk_50,
    input  logic       rst_n,
    input  logic       key_valid,
    input  logic [7:0] key_code,
    output logic [7:0] key_held
);

    localparam int CW = $clog2(HOLD_CYCLES + 1);

    logic [CW-1:0] hold_cnt;

    // A strobe reloads the key and the timer so a repeated key stays pressed
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            key_held <= KEY_NONE;
            hold_cnt <= '0;
        end else if (key_valid) begin
            key_held <= key_code;
            hold_cnt <= CW'(HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
            if (hold_cnt == CW'(1)) begin
                key_held <= KEY_NONE;          // Hold time over
            end
        end
    end

endmodule

/* hdl/motor_pwm.sv */
`timescale 1ns/100ps

module motor_pwm
    import robot_pkg::*;
#(
    parameter int PWM_PERIOD = 2000
) (
    input  logic       clk_50,
    input  logic       rst_n,
    input  drive_cmd_t drive_cmd,
    output logic       pwm_left,
    output logic       pwm_right,
    output motor_dir_t dir_left,
    output motor_dir_t dir_right
);

    localparam int W = $clog2(PWM_PERIOD + 1);
    localparam logic [W-1:0] QUARTER = W'(PWM_PERIOD / 4);
    localparam logic [W-1:0] LAST    = W'(PWM_PERIOD - 1);

    logic [1:0]   quarters_l;
    logic [1:0]   quarters_r;
    motor_dir_t   dir_l_nxt;
    motor_dir_t   dir_r_nxt;
    logic [W-1:0] cnt;
    logic [W-1:0] duty_l;
    logic [W-1:0] duty_r;

    always_comb begin
        quarters_l = 2'd0;
        quarters_r = 2'd0;
        dir_l_nxt  = dir_fwd;
        dir_r_nxt  = dir_fwd;
        case (drive_cmd)
            cmd_slow:   begin quarters_l = 2'd1; quarters_r = 2'd1; end
            cmd_medium: begin quarters_l = 2'd2; quarters_r = 2'd2; end
            cmd_fast:   begin quarters_l = 2'd3; quarters_r = 2'd3; end
            cmd_left:   quarters_r = 2'd2;               // Only the right wheel turns
            cmd_right:  quarters_l = 2'd2;
            cmd_reverse: begin
                quarters_l = 2'd2;
                quarters_r = 2'd2;
                dir_l_nxt  = dir_bwd;
                dir_r_nxt  = dir_bwd;
            end
            cmd_lreverse: begin
                quarters_r = 2'd2;
                dir_l_nxt  = dir_bwd;
                dir_r_nxt  = dir_bwd;
            end
            cmd_rreverse: begin
                quarters_l = 2'd2;
                dir_l_nxt  = dir_bwd;
                dir_r_nxt  = dir_bwd;
            end
            cmd_hard_l: begin                        // Spin in place
                quarters_l = 2'd3;
                quarters_r = 2'd3;
                dir_l_nxt  = dir_bwd;
            end
            cmd_hard_r: begin
                quarters_l = 2'd3;
                quarters_r = 2'd3;
                dir_r_nxt  = dir_bwd;
            end
            default: ;                               // Stop
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            cnt       <= '0;
            duty_l    <= '0;
            duty_r    <= '0;
            dir_left  <= dir_fwd;
            dir_right <= dir_fwd;
        end else begin
            dir_left  <= dir_l_nxt;
            dir_right <= dir_r_nxt;
            if (cnt == LAST) begin
                cnt    <= '0;
                duty_l <= W'(quarters_l) * QUARTER;  // New duty from next period
                duty_r <= W'(quarters_r) * QUARTER;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign pwm_left  = (cnt < duty_l);
    assign pwm_right = (cnt < duty_r);

    duty_in_range: assert property (
        @(posedge clk_50) disable iff (!rst_n)
        (duty_l <= W'(PWM_PERIOD)) && (duty_r <= W'(PWM_PERIOD))
    );

endmodule

/* hdl/robot_top.sv */
`timescale 1ns/100ps

module robot_top
    import robot_pkg::*;
    import ir_keys_pkg::*;
#(
    parameter int HOLD_CYCLES = 5_000_000,   // About 100 ms at 50 MHz
    parameter int PWM_PERIOD  = 2000
) (
    input  logic       clk_50,
    input  logic       rst_n,
    input  logic       key_valid,
    input  logic [7:0] key_code,
    input  cam_dir_t   cam_dir,
    input  logic       orange_detected,
    input  speed_t     speed,
    output logic       pwm_left,
    output logic       pwm_right,
    output motor_dir_t dir_left,
    output motor_dir_t dir_right,
    output mode_t      mode,
    output cam_state_t cam_state,
    output drive_cmd_t drive_cmd,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex6,
    output logic [6:0] hex7
);

    logic [7:0] key_held;

    ir_key_hold #(
        .HOLD_CYCLES(HOLD_CYCLES)
    ) i_ir_key_hold (
        .clk_50   (clk_50),
        .rst_n    (rst_n),
        .key_valid(key_valid),
        .key_code (key_code),
        .key_held (key_held)
    );

    mode_fsm i_mode_fsm (
        .clk_50         (clk_50),
        .rst_n          (rst_n),
        .key_held       (key_held),
        .cam_dir        (cam_dir),
        .orange_detected(orange_detected),
        .speed          (speed),
        .mode           (mode),
        .cam_state      (cam_state),
        .drive_cmd      (drive_cmd)
    );

    motor_pwm #(
        .PWM_PERIOD(PWM_PERIOD)
    ) i_motor_pwm (
        .clk_50   (clk_50),
        .rst_n    (rst_n),
        .drive_cmd(drive_cmd),
        .pwm_left (pwm_left),
        .pwm_right(pwm_right),
        .dir_left (dir_left),
        .dir_right(dir_right)
    );

    seg_display i_seg_display (
        .mode     (mode),
        .cam_state(cam_state),
        .drive_cmd(drive_cmd),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex6     (hex6),
        .hex7     (hex7)
    );

endmodule

/* hdl/seg_display.sv */
`timescale 1ns/100ps

module seg_display
    import robot_pkg::*;
(
    input  mode_t      mode,
    input  cam_state_t cam_state,
    input  drive_cmd_t drive_cmd,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex6,
    output logic [6:0] hex7
);

    // Active-low segments, bit 6 is segment g
    localparam logic [6:0] SEG_A     = 7'b0001000;
    localparam logic [6:0] SEG_C     = 7'b1000110;
    localparam logic [6:0] SEG_D     = 7'b0100001;
    localparam logic [6:0] SEG_E     = 7'b0000110;
    localparam logic [6:0] SEG_F     = 7'b0001110;
    localparam logic [6:0] SEG_G     = 7'b0000010;
    localparam logic [6:0] SEG_H     = 7'b0001001;
    localparam logic [6:0] SEG_I     = 7'b1111001;
    localparam logic [6:0] SEG_L     = 7'b1000111;
    localparam logic [6:0] SEG_O     = 7'b1000000;
    localparam logic [6:0] SEG_P     = 7'b0001100;
    localparam logic [6:0] SEG_R     = 7'b0101111;
    localparam logic [6:0] SEG_S     = 7'b0010010;
    localparam logic [6:0] SEG_T     = 7'b0001111;
    localparam logic [6:0] SEG_1     = 7'b1111001;
    localparam logic [6:0] SEG_2     = 7'b0100100;
    localparam logic [6:0] SEG_3     = 7'b0110000;
    localparam logic [6:0] SEG_BLANK = 7'b1111111;

    always_comb begin
        case (mode)
            mode_idle: {hex7, hex6} = {SEG_I, SEG_D};
            mode_cam:  {hex7, hex6} = {SEG_C, SEG_A};
            mode_ir:   {hex7, hex6} = {SEG_I, SEG_R};
            default:   {hex7, hex6} = {SEG_BLANK, SEG_BLANK};
        endcase
    end

    always_comb begin
        case (cam_state)
            cam_search: hex4 = SEG_S;
            cam_follow: hex4 = SEG_F;
            cam_pause:  hex4 = SEG_P;
            default:    hex4 = SEG_BLANK;
        endcase
    end

    // Command word on hex3..hex0, reverse and spin commands stay dark
    always_comb begin
        case (drive_cmd)
            cmd_left:   {hex3, hex2, hex1, hex0} = {SEG_L, SEG_E, SEG_F, SEG_T};
            cmd_right:  {hex3, hex2, hex1, hex0} = {SEG_R, SEG_G, SEG_H, SEG_T};
            cmd_slow:   {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_1};
            cmd_medium: {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_2};
            cmd_fast:   {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_3};
            cmd_stop:   {hex3, hex2, hex1, hex0} = {SEG_S, SEG_T, SEG_O, SEG_P};
            default:    {hex3, hex2, hex1, hex0} = {4{SEG_BLANK}};
        endcase
    end

endmodule

/* mode_fsm/mode_fsm.sv */
`timescale 1ns/100ps

module mode_fsm
    import robot_pkg::*;
    import ir_keys_pkg::*;
(
    input  logic       clk_50,
    input  logic       rst_n,
    input  logic [7:0] key_held,
    input  cam_dir_t   cam_dir,
    input  logic       orange_detected,
    input  speed_t     speed,
    output mode_t      mode,
    output cam_state_t cam_state,
    output drive_cmd_t drive_cmd
);

    mode_t      next_mode;
    cam_state_t next_cam;
    drive_cmd_t next_cmd;

    always_comb begin
        case (key_held)
            KEY_CAM:  next_mode = mode_cam;
            KEY_IR:   next_mode = mode_ir;
            KEY_IDLE: next_mode = mode_idle;
            default:  next_mode = mode;      // Other keys keep the mode
        endcase
    end

    always_comb begin
        if (next_mode != mode_cam) begin
            next_cam = cam_pause;
        end else begin
            case (cam_state)
                cam_search, cam_follow: next_cam = orange_detected ? cam_follow : cam_search;
                default:    next_cam = cam_search;   // Just entered camera mode
            endcase
        end
    end

    always_comb begin
        next_cmd = cmd_stop;
        case (next_mode)
            mode_cam: begin
                if (speed == spd_halt) begin
                    next_cmd = cmd_stop;
                end else if (cam_dir == cdir_right) begin
                    next_cmd = cmd_right;
                end else if (cam_dir == cdir_left) begin
                    next_cmd = cmd_left;
                end else if (next_cam == cam_follow && cam_dir == cdir_center) begin
                    case (speed)
                        spd_slow:   next_cmd = cmd_slow;
                        spd_medium: next_cmd = cmd_medium;
                        spd_fast:   next_cmd = cmd_fast;
                        default:    next_cmd = cmd_stop;
                    endcase
                end
            end
            mode_ir: begin
                if (speed == spd_halt) begin
                    next_cmd = cmd_stop;
                end else if (orange_detected) begin
                    // Steer away from the obstacle
                    case (cam_dir)
                        cdir_right:  next_cmd = cmd_hard_l;
                        cdir_left:   next_cmd = cmd_hard_r;
                        cdir_center: next_cmd = cmd_reverse;
                        default:     next_cmd = cmd_stop;
                    endcase
                end else begin
                    case (key_held)
                        KEY_LEFT:     next_cmd = cmd_left;
                        KEY_RIGHT:    next_cmd = cmd_right;
                        KEY_FAST:     next_cmd = cmd_fast;
                        KEY_MEDIUM:   next_cmd = cmd_medium;
                        KEY_SLOW:     next_cmd = cmd_slow;
                        KEY_REVERSE:  next_cmd = cmd_reverse;
                        KEY_LREVERSE: next_cmd = cmd_lreverse;
                        KEY_RREVERSE: next_cmd = cmd_rreverse;
                        default:      next_cmd = cmd_stop;   // KEY_STOP and the rest
                    endcase
                end
            end
            default: next_cmd = cmd_stop;
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            mode      <= mode_idle;
            cam_state <= cam_pause;
            drive_cmd <= cmd_stop;
        end else begin
            mode      <= next_mode;
            cam_state <= next_cam;
            drive_cmd <= next_cmd;
        end
    end

    pause_outside_cam: assert property (
        @(posedge clk_50) disable iff (!rst_n)
        (mode != mode_cam) |-> (cam_state == cam_pause)
    );

    stop_in_idle: assert property (
        @(posedge clk_50) disable iff (!rst_n)
        (mode == mode_idle) |-> (drive_cmd == cmd_stop)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the robot controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module robot_tb -f files.f -o robot_sim

./obj_dir/robot_sim | tee sim.log

# The run passes only if the testbench reported success
grep -qF "*** TEST PASSED ***" sim.log

/* tb/robot_tb.sv */
`timescale 1ns/100ps

module robot_tb
    import robot_pkg::*;
    import ir_keys_pkg::*;
();

    localparam int HOLD_CYCLES = 6;
    localparam int PWM_PERIOD  = 8;

    localparam logic [7:0] KNOWN_KEYS [12] = '{KEY_CAM, KEY_IR, KEY_IDLE, KEY_STOP, KEY_LEFT,
        KEY_RIGHT, KEY_FAST, KEY_MEDIUM, KEY_SLOW, KEY_REVERSE, KEY_LREVERSE, KEY_RREVERSE};

    // Active-low letters, bit 6 is segment g
    localparam logic [6:0] CH_A = 7'b0001000;
    localparam logic [6:0] CH_C = 7'b1000110;
    localparam logic [6:0] CH_D = 7'b0100001;
    localparam logic [6:0] CH_E = 7'b0000110;
    localparam logic [6:0] CH_F = 7'b0001110;
    localparam logic [6:0] CH_G = 7'b0000010;
    localparam logic [6:0] CH_H = 7'b0001001;
    localparam logic [6:0] CH_I = 7'b1111001;
    localparam logic [6:0] CH_L = 7'b1000111;
    localparam logic [6:0] CH_O = 7'b1000000;
    localparam logic [6:0] CH_P = 7'b0001100;
    localparam logic [6:0] CH_R = 7'b0101111;
    localparam logic [6:0] CH_S = 7'b0010010;
    localparam logic [6:0] CH_T = 7'b0001111;
    localparam logic [6:0] CH_1 = 7'b1111001;
    localparam logic [6:0] CH_2 = 7'b0100100;
    localparam logic [6:0] CH_3 = 7'b0110000;
    localparam logic [6:0] CH_OFF = 7'b1111111;

    logic       clk_50;
    logic       rst_n;
    logic       key_valid;
    logic [7:0] key_code;
    cam_dir_t   cam_dir;
    logic       orange_detected;
    speed_t     speed;
    logic       pwm_left;
    logic       pwm_right;
    motor_dir_t dir_left;
    motor_dir_t dir_right;
    mode_t      mode;
    cam_state_t cam_state;
    drive_cmd_t drive_cmd;
    logic [6:0] hex0, hex1, hex2, hex3, hex4, hex6, hex7;

    // Reference model state
    logic [7:0] m_held;
    int         m_hold;
    mode_t      m_mode;
    cam_state_t m_cam;
    drive_cmd_t m_cmd;
    motor_dir_t m_dir_l;
    motor_dir_t m_dir_r;
    int         m_phase;
    int         m_duty_l;
    int         m_duty_r;
    int         hi_l;
    int         hi_r;
    int         mismatches;
    int         timeouts;
    integer     seed;

    robot_top #(
        .HOLD_CYCLES(HOLD_CYCLES),
        .PWM_PERIOD (PWM_PERIOD)
    ) i_robot_top (
        .clk_50(clk_50), .rst_n(rst_n), .key_valid(key_valid), .key_code(key_code),
        .cam_dir(cam_dir), .orange_detected(orange_detected), .speed(speed),
        .pwm_left(pwm_left), .pwm_right(pwm_right), .dir_left(dir_left),
        .dir_right(dir_right), .mode(mode), .cam_state(cam_state), .drive_cmd(drive_cmd),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4),
        .hex6(hex6), .hex7(hex7)
    );

    initial begin
        clk_50 = 1'b0;
        forever #4 clk_50 = ~clk_50;
    end

    function automatic drive_cmd_t expect_cmd(mode_t nm, cam_state_t ncs, logic [7:0] held);
        drive_cmd_t c;
        c = cmd_stop;
        if (nm == mode_cam && speed != spd_halt) begin
            if (cam_dir == cdir_right) c = cmd_right;
            else if (cam_dir == cdir_left) c = cmd_left;
            else if (ncs == cam_follow && cam_dir == cdir_center) begin
                c = (speed == spd_slow) ? cmd_slow : (speed == spd_medium) ? cmd_medium : cmd_fast;
            end
        end else if (nm == mode_ir && speed != spd_halt) begin
            if (orange_detected) begin          // Obstacle override
                if (cam_dir == cdir_right) c = cmd_hard_l;
                else if (cam_dir == cdir_left) c = cmd_hard_r;
                else if (cam_dir == cdir_center) c = cmd_reverse;
            end else begin
                case (held)
                    KEY_LEFT:     c = cmd_left;
                    KEY_RIGHT:    c = cmd_right;
                    KEY_FAST:     c = cmd_fast;
                    KEY_MEDIUM:   c = cmd_medium;
                    KEY_SLOW:     c = cmd_slow;
                    KEY_REVERSE:  c = cmd_reverse;
                    KEY_LREVERSE: c = cmd_lreverse;
                    KEY_RREVERSE: c = cmd_rreverse;
                    default:      c = cmd_stop;
                endcase
            end
        end
        return c;
    endfunction

    // {left quarters, right quarters, left dir, right dir}
    function automatic logic [5:0] motor_row(drive_cmd_t c);
        case (c)
            cmd_slow:     return 6'b01_01_00;
            cmd_medium:   return 6'b10_10_00;
            cmd_fast:     return 6'b11_11_00;
            cmd_left:     return 6'b00_10_00;
            cmd_right:    return 6'b10_00_00;
            cmd_reverse:  return 6'b10_10_11;
            cmd_lreverse: return 6'b00_10_11;
            cmd_rreverse: return 6'b10_00_11;
            cmd_hard_l:   return 6'b11_11_10;
            cmd_hard_r:   return 6'b11_11_01;
            default:      return 6'b00_00_00;
        endcase
    endfunction

    function automatic logic [13:0] mode_word(mode_t md);
        if (md == mode_cam) return {CH_C, CH_A};
        if (md == mode_ir) return {CH_I, CH_R};
        return {CH_I, CH_D};
    endfunction

    function automatic logic [6:0] state_letter(cam_state_t cs);
        if (cs == cam_search) return CH_S;
        if (cs == cam_follow) return CH_F;
        return CH_P;
    endfunction

    function automatic logic [27:0] cmd_word(drive_cmd_t c);
        case (c)
            cmd_left:   return {CH_L, CH_E, CH_F, CH_T};
            cmd_right:  return {CH_R, CH_G, CH_H, CH_T};
            cmd_slow:   return {CH_S, CH_P, CH_OFF, CH_1};
            cmd_medium: return {CH_S, CH_P, CH_OFF, CH_2};
            cmd_fast:   return {CH_S, CH_P, CH_OFF, CH_3};
            cmd_stop:   return {CH_S, CH_T, CH_O, CH_P};
            default:    return {4{CH_OFF}};
        endcase
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            mismatches++;
            $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
        end
    endtask

    // One clock edge of the whole controller
    task automatic step_model();
        mode_t      nm;
        cam_state_t ncs;
        logic [5:0] row;
        if (m_held == KEY_CAM) nm = mode_cam;
        else if (m_held == KEY_IR) nm = mode_ir;
        else if (m_held == KEY_IDLE) nm = mode_idle;
        else nm = m_mode;
        if (nm != mode_cam) ncs = cam_pause;
        else if (m_cam == cam_pause) ncs = cam_search;
        else ncs = orange_detected ? cam_follow : cam_search;
        row = motor_row(m_cmd);
        m_dir_l = motor_dir_t'(row[1]);
        m_dir_r = motor_dir_t'(row[0]);
        if (m_phase == PWM_PERIOD - 1) begin
            m_phase  = 0;
            m_duty_l = int'(row[5:4]) * (PWM_PERIOD / 4);
            m_duty_r = int'(row[3:2]) * (PWM_PERIOD / 4);
        end else begin
            m_phase++;
        end
        m_cmd  = expect_cmd(nm, ncs, m_held);
        m_mode = nm;
        m_cam  = ncs;
        if (key_valid) begin
            m_held = key_code;
            m_hold = HOLD_CYCLES;
        end else if (m_hold > 0) begin
            m_hold--;
            if (m_hold == 0) m_held = KEY_NONE;
        end
    endtask

    task automatic check_outputs();
        check_field("mode", 32'(mode), 32'(m_mode));
        check_field("cam_state", 32'(cam_state), 32'(m_cam));
        check_field("drive_cmd", 32'(drive_cmd), 32'(m_cmd));
        check_field("dir_left", 32'(dir_left), 32'(m_dir_l));
        check_field("dir_right", 32'(dir_right), 32'(m_dir_r));
        check_field("hex7 hex6", 32'({hex7, hex6}), 32'(mode_word(m_mode)));
        check_field("hex4", 32'(hex4), 32'(state_letter(m_cam)));
        check_field("hex3..hex0", 32'({hex3, hex2, hex1, hex0}), 32'(cmd_word(m_cmd)));
    endtask

    task automatic cycle();
        @(posedge clk_50);
        step_model();
        @(negedge clk_50);
        check_outputs();
        if (pwm_left) hi_l++;
        if (pwm_right) hi_r++;
        if (m_phase == PWM_PERIOD - 1) begin   // Full period seen
            check_field("pwm_left high cycles", 32'(hi_l), 32'(m_duty_l));
            check_field("pwm_right high cycles", 32'(hi_r), 32'(m_duty_r));
            hi_l = 0;
            hi_r = 0;
        end
    endtask

    task automatic send_key(input logic [7:0] k);
        key_valid = 1'b1;
        key_code  = k;
        cycle();
        key_valid = 1'b0;
    endtask

    task automatic wait_mode(input mode_t md, input int limit);
        int n;
        n = 0;
        while (mode != md && n < limit) begin
            cycle();
            n++;
        end
        if (mode != md) begin
            timeouts++;
            $display("timeout: mode %0d not reached within %0d cycles", md, limit);
        end
    endtask

    task automatic wait_cmd(input drive_cmd_t c, input int limit);
        int n;
        n = 0;
        while (drive_cmd != c && n < limit) begin
            cycle();
            n++;
        end
        if (drive_cmd != c) begin
            timeouts++;
            $display("timeout: drive command %0d not reached within %0d cycles", c, limit);
        end
    endtask

    task automatic drive_random();
        logic [31:0] r;
        int          idx;
        r         = $random(seed);
        idx       = int'(r[11:8]) % 12;
        key_valid = (r[2:0] == 3'd0);
        key_code  = r[3] ? KNOWN_KEYS[idx] : r[23:16];
        if (r[27:26] == 2'd0) begin
            cam_dir         = cam_dir_t'({1'b0, r[13:12]});
            orange_detected = r[14];
        end
        if (r[31:28] == 4'd0) speed = speed_t'(r[25:24]);
    endtask

    initial begin
        seed = 16;
        mismatches = 0;
        timeouts = 0;
        rst_n = 1'b0;
        key_valid = 1'b0;
        key_code = 8'h00;
        cam_dir = cdir_none;
        orange_detected = 1'b0;
        speed = spd_medium;
        m_held = KEY_NONE;
        m_hold = 0;
        m_mode = mode_idle;
        m_cam = cam_pause;
        m_cmd = cmd_stop;
        m_dir_l = dir_fwd;
        m_dir_r = dir_fwd;
        m_phase = 0;
        m_duty_l = 0;
        m_duty_r = 0;
        hi_l = 0;
        hi_r = 0;
        repeat (5) @(posedge clk_50);
        @(negedge clk_50);
        check_outputs();                        // Reset display
        rst_n = 1'b1;

        send_key(KEY_IR);
        wait_mode(mode_ir, 4);
        send_key(KEY_LEFT);
        wait_cmd(cmd_left, 4);
        repeat (3) cycle();
        send_key(KEY_LEFT);                     // Repeat strobe extends the hold
        wait_cmd(cmd_stop, 12);
        send_key(KEY_CAM);
        wait_mode(mode_cam, 4);
        cam_dir = cdir_center;
        orange_detected = 1'b1;
        wait_cmd(cmd_medium, 6);

        repeat (3000) begin
            drive_random();
            cycle();
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
